//--- build.f
+incdir+include
design/eth_loop_pkg.sv
design/mem_port_if.sv
design/link_startup.sv
design/cross_buffer.sv
design/beat_store_arbiter.sv
design/eth_loop_top.sv
test/eth_loop_props.sv
test/eth_loop_tb.sv

//--- design/beat_store_arbiter.sv
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module beat_store_arbiter (
	input  logic      clk156,
	input  logic      eth_rst,
	mem_port_if.store port_a,
	mem_port_if.store port_b
);
	import eth_loop_pkg::*;

	localparam int STORE_DEPTH = 2 * `ETH_REGION_DEPTH;

	eth_beat_t   store_mem [STORE_DEPTH];
	eth_beat_t   wr_data;
	eth_beat_t   rd_data;
	store_addr_t wr_addr;
	store_addr_t rd_addr;

	logic wr_rr; // set favors port b on a tie
	logic rd_rr;
	logic wr_gnt_a;
	logic wr_gnt_b;
	logic rd_gnt_a;
	logic rd_gnt_b;
	logic rd_valid_a;
	logic rd_valid_b;

	// grants decided in the request cycle
	assign wr_gnt_a = port_a.wr_req && (!port_b.wr_req || !wr_rr);
	assign wr_gnt_b = port_b.wr_req && (!port_a.wr_req || wr_rr);
	assign rd_gnt_a = port_a.rd_req && (!port_b.rd_req || !rd_rr);
	assign rd_gnt_b = port_b.rd_req && (!port_a.rd_req || rd_rr);

	// port b owns the upper region
	assign wr_addr = wr_gnt_b ? store_addr_t'{port: 1'b1, idx: port_b.wr_idx}
	                          : store_addr_t'{port: 1'b0, idx: port_a.wr_idx};
	assign wr_data = wr_gnt_b ? port_b.wr_beat : port_a.wr_beat;
	assign rd_addr = rd_gnt_b ? store_addr_t'{port: 1'b1, idx: port_b.rd_idx}
	                          : store_addr_t'{port: 1'b0, idx: port_a.rd_idx};

	assign port_a.wr_gnt   = wr_gnt_a;
	assign port_b.wr_gnt   = wr_gnt_b;
	assign port_a.rd_gnt   = rd_gnt_a;
	assign port_b.rd_gnt   = rd_gnt_b;
	assign port_a.rd_valid = rd_valid_a;
	assign port_b.rd_valid = rd_valid_b;
	assign port_a.rd_beat  = rd_data; // rd_valid tells the owner of the shared data
	assign port_b.rd_beat  = rd_data;

	always_ff @(posedge clk156) begin
		if (wr_gnt_a || wr_gnt_b)
			store_mem[wr_addr] <= wr_data;
		if (rd_gnt_a || rd_gnt_b)
			rd_data <= store_mem[rd_addr];
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_rr      <= 1'b0;
			rd_rr      <= 1'b0;
			rd_valid_a <= 1'b0;
			rd_valid_b <= 1'b0;
		end else begin
			if (port_a.wr_req && port_b.wr_req)
				wr_rr <= !wr_rr; // other side wins next tie
			if (port_a.rd_req && port_b.rd_req)
				rd_rr <= !rd_rr;
			rd_valid_a <= rd_gnt_a;
			rd_valid_b <= rd_gnt_b;
		end
	end

endmodule

`default_nettype wire

//--- design/cross_buffer.sv
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module cross_buffer (
	input  logic                  clk156,
	input  logic                  eth_rst,
	input  logic                  tx_release,
	input  logic                  rx_valid,
	input  eth_loop_pkg::eth_beat_t rx_beat,
	output logic                  tx_valid,
	input  logic                  tx_ready,
	output eth_loop_pkg::eth_beat_t tx_beat,
	output logic                  overflow,
	mem_port_if.buffer            mem
);
	import eth_loop_pkg::*;

	localparam int STG_W = $clog2(`ETH_STAGE_DEPTH);
	localparam logic [STG_W-1:0] STG_LAST = STG_W'(`ETH_STAGE_DEPTH - 1);
	localparam logic [STG_W:0]   STG_FULL = (STG_W+1)'(`ETH_STAGE_DEPTH);
	localparam occ_t             OCC_MAX  = occ_t'(`ETH_REGION_DEPTH);

	// write staging queue
	eth_beat_t        stg_mem [`ETH_STAGE_DEPTH];
	logic [STG_W-1:0] stg_wp;
	logic [STG_W-1:0] stg_rp;
	logic [STG_W:0]   stg_cnt;

	// region bookkeeping
	region_idx_t wr_ptr;
	region_idx_t rd_ptr;
	occ_t        occ;    // accepted, not yet sent
	occ_t        stored; // in store, read not yet issued

	// transmit skid stage
	eth_beat_t  skid_mem [2];
	logic       skid_wp;
	logic       skid_rp;
	logic [1:0] skid_cnt;

	logic rx_accept;
	logic stg_pop;
	logic tx_pop;
	logic rd_room;

	function automatic logic [STG_W-1:0] stg_next(input logic [STG_W-1:0] p);
		return (p == STG_LAST) ? '0 : p + 1'b1;
	endfunction

	// skid entries plus the one arriving now must leave a slot
	assign rd_room   = (skid_cnt + {1'b0, mem.rd_valid}) < 2'd2;
	assign rx_accept = rx_valid && (occ < OCC_MAX) && (stg_cnt < STG_FULL);
	assign stg_pop   = mem.wr_gnt;
	assign tx_pop    = tx_valid && tx_ready;

	assign mem.wr_req  = (stg_cnt != '0);
	assign mem.wr_idx  = wr_ptr;
	assign mem.wr_beat = stg_mem[stg_rp]; // head holds until granted

	// stays asserted until granted, room cannot shrink meanwhile
	assign mem.rd_req = tx_release && (stored != '0) && rd_room;
	assign mem.rd_idx = rd_ptr;

	assign tx_valid = (skid_cnt != 2'd0);
	assign tx_beat  = skid_mem[skid_rp];

	always_ff @(posedge clk156) begin
		if (rx_accept)
			stg_mem[stg_wp] <= rx_beat;
		if (mem.rd_valid)
			skid_mem[skid_wp] <= mem.rd_beat;
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			stg_wp   <= '0;
			stg_rp   <= '0;
			stg_cnt  <= '0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			occ      <= '0;
			stored   <= '0;
			skid_wp  <= 1'b0;
			skid_rp  <= 1'b0;
			skid_cnt <= 2'd0;
			overflow <= 1'b0;
		end else begin
			if (rx_accept)
				stg_wp <= stg_next(stg_wp);
			if (stg_pop) begin
				stg_rp <= stg_next(stg_rp);
				wr_ptr <= wr_ptr + 1'b1; // wraps inside the region
			end
			if (mem.rd_gnt)
				rd_ptr <= rd_ptr + 1'b1;
			stg_cnt <= stg_cnt + {{STG_W{1'b0}}, rx_accept} - {{STG_W{1'b0}}, stg_pop};
			occ     <= occ + occ_t'(rx_accept) - occ_t'(tx_pop);
			stored  <= stored + occ_t'(mem.wr_gnt) - occ_t'(mem.rd_gnt);

			skid_wp  <= skid_wp ^ mem.rd_valid;
			skid_rp  <= skid_rp ^ tx_pop;
			skid_cnt <= skid_cnt + {1'b0, mem.rd_valid} - {1'b0, tx_pop};

			if (rx_valid && !rx_accept)
				overflow <= 1'b1; // sticky until reset
		end
	end

endmodule

`default_nettype wire

//--- design/eth_loop_pkg.sv
`include "eth_loop_settings.svh"
`default_nettype none

package eth_loop_pkg;

	// one stream beat, also the store word
	typedef struct packed {
		logic [`ETH_DATA_W-1:0] data;
		logic [`ETH_KEEP_W-1:0] keep;
		logic                   last;
	} eth_beat_t;

	// slot inside one direction's region
	typedef logic [$clog2(`ETH_REGION_DEPTH)-1:0] region_idx_t;

	// full store address, region select on top
	typedef struct packed {
		logic        port;
		region_idx_t idx;
	} store_addr_t;

	// 0 .. ETH_REGION_DEPTH inclusive
	typedef logic [$clog2(`ETH_REGION_DEPTH):0] occ_t;

endpackage

`default_nettype wire

//--- design/eth_loop_top.sv
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module eth_loop_top (
	input  logic                  clk156,
	input  logic                  eth_rst,

	input  logic                  rx0_valid,
	input  logic [`ETH_DATA_W-1:0] rx0_data,
	input  logic [`ETH_KEEP_W-1:0] rx0_keep,
	input  logic                  rx0_last,

	input  logic                  rx1_valid,
	input  logic [`ETH_DATA_W-1:0] rx1_data,
	input  logic [`ETH_KEEP_W-1:0] rx1_keep,
	input  logic                  rx1_last,

	output logic                  tx0_valid,
	input  logic                  tx0_ready,
	output logic [`ETH_DATA_W-1:0] tx0_data,
	output logic [`ETH_KEEP_W-1:0] tx0_keep,
	output logic                  tx0_last,

	output logic                  tx1_valid,
	input  logic                  tx1_ready,
	output logic [`ETH_DATA_W-1:0] tx1_data,
	output logic [`ETH_KEEP_W-1:0] tx1_keep,
	output logic                  tx1_last,

	output logic                  overflow0,
	output logic                  overflow1
);
	import eth_loop_pkg::*;

	logic      tx_release;
	eth_beat_t rx0_beat;
	eth_beat_t rx1_beat;
	eth_beat_t tx0_beat;
	eth_beat_t tx1_beat;

	mem_port_if mem_a ();
	mem_port_if mem_b ();

	assign rx0_beat = '{data: rx0_data, keep: rx0_keep, last: rx0_last};
	assign rx1_beat = '{data: rx1_data, keep: rx1_keep, last: rx1_last};

	assign tx0_data = tx0_beat.data;
	assign tx0_keep = tx0_beat.keep;
	assign tx0_last = tx0_beat.last;
	assign tx1_data = tx1_beat.data;
	assign tx1_keep = tx1_beat.keep;
	assign tx1_last = tx1_beat.last;

	link_startup u_startup (
		.clk156     (clk156),
		.eth_rst    (eth_rst),
		.tx_release (tx_release)
	);

	// rx0 to tx1
	cross_buffer dir_a (
		.clk156     (clk156),
		.eth_rst    (eth_rst),
		.tx_release (tx_release),
		.rx_valid   (rx0_valid),
		.rx_beat    (rx0_beat),
		.tx_valid   (tx1_valid),
		.tx_ready   (tx1_ready),
		.tx_beat    (tx1_beat),
		.overflow   (overflow0),
		.mem        (mem_a)
	);

	// rx1 to tx0
	cross_buffer dir_b (
		.clk156     (clk156),
		.eth_rst    (eth_rst),
		.tx_release (tx_release),
		.rx_valid   (rx1_valid),
		.rx_beat    (rx1_beat),
		.tx_valid   (tx0_valid),
		.tx_ready   (tx0_ready),
		.tx_beat    (tx0_beat),
		.overflow   (overflow1),
		.mem        (mem_b)
	);

	beat_store_arbiter u_store (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.port_a  (mem_a),
		.port_b  (mem_b)
	);

endmodule

`default_nettype wire

//--- design/link_startup.sv
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module link_startup (
	input  logic clk156,
	input  logic eth_rst,
	output logic tx_release
);

	localparam logic [1:0] ST_IDLE     = 2'd0;
	localparam logic [1:0] ST_COUNT    = 2'd1;
	localparam logic [1:0] ST_RELEASED = 2'd2;

	localparam int CNT_W = $clog2(`ETH_PREFILL + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`ETH_PREFILL - 1);

	logic [1:0]       state;
	logic [CNT_W-1:0] wait_cnt;

	// idle takes one edge, count takes ETH_PREFILL edges
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			state    <= ST_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: state <= ST_COUNT;
				ST_COUNT: begin
					if (wait_cnt == CNT_LAST)
						state <= ST_RELEASED;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				ST_RELEASED: state <= ST_RELEASED; // held until reset
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign tx_release = (state == ST_RELEASED);

endmodule

`default_nettype wire

//--- design/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
	import eth_loop_pkg::*;

	// write channel, held until wr_gnt
	logic        wr_req;
	logic        wr_gnt;
	region_idx_t wr_idx;
	eth_beat_t   wr_beat;

	// read channel, data one clock after rd_gnt
	logic        rd_req;
	logic        rd_gnt;
	region_idx_t rd_idx;
	logic        rd_valid;
	eth_beat_t   rd_beat;

	modport buffer (
		output wr_req, wr_idx, wr_beat,
		input  wr_gnt,
		output rd_req, rd_idx,
		input  rd_gnt, rd_valid, rd_beat
	);

	modport store (
		input  wr_req, wr_idx, wr_beat,
		output wr_gnt,
		input  rd_req, rd_idx,
		output rd_gnt, rd_valid, rd_beat
	);

endinterface

`default_nettype wire

//--- include/eth_loop_settings.svh
`ifndef ETH_LOOP_SETTINGS_SVH
`define ETH_LOOP_SETTINGS_SVH

`default_nettype none

// beat layout
`define ETH_DATA_W 64
`define ETH_KEEP_W 8

// beats of store per direction, power of two
`define ETH_REGION_DEPTH 64

// transmit hold after reset, clk156 cycles
`define ETH_PREFILL 32

// write staging slots per cross buffer
`define ETH_STAGE_DEPTH 2

`default_nettype wire

`endif

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module eth_loop_tb -o sim_eth_loop

./obj_dir/sim_eth_loop 2>&1 | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- test/eth_loop_props.sv
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module eth_loop_props (
	input logic                                  clk156,
	input logic                                  eth_rst,
	input logic                                  tx_release,
	input logic                                  tx0_valid,
	input logic                                  tx0_ready,
	input logic [`ETH_DATA_W+`ETH_KEEP_W:0]      tx0_word,
	input logic                                  tx1_valid,
	input logic                                  tx1_ready,
	input logic [`ETH_DATA_W+`ETH_KEEP_W:0]      tx1_word,
	input logic                                  overflow0,
	input logic                                  overflow1,
	input logic [5:0]                            mem_flags
);

	int unsigned since_rst; // saturates one past the prefill
	int unsigned fail_count = 0; // assertion failures so far

	always_ff @(posedge clk156) begin
		if (eth_rst)
			since_rst <= 0;
		else if (since_rst <= `ETH_PREFILL)
			since_rst <= since_rst + 1;
	end

	release_timing: assert property (@(posedge clk156) disable iff (eth_rst)
		tx_release == (since_rst > `ETH_PREFILL))
		else begin
			fail_count++;
			$error("release not exactly ETH_PREFILL+1 cycles after reset");
		end

	startup_hold: assert property (@(posedge clk156) disable iff (eth_rst)
		!tx_release |-> !tx0_valid && !tx1_valid)
		else begin
			fail_count++;
			$error("transmit valid before release");
		end

	reset_quiet: assert property (@(posedge clk156)
		$past(eth_rst) |-> !(tx0_valid || tx1_valid || overflow0 || overflow1 || (|mem_flags)))
		else begin
			fail_count++;
			$error("outputs or grants active right after reset");
		end

	tx0_stable: assert property (@(posedge clk156) disable iff (eth_rst)
		tx0_valid && !tx0_ready |=> tx0_valid && $stable(tx0_word))
		else begin
			fail_count++;
			$error("tx0 beat changed while stalled");
		end

	tx1_stable: assert property (@(posedge clk156) disable iff (eth_rst)
		tx1_valid && !tx1_ready |=> tx1_valid && $stable(tx1_word))
		else begin
			fail_count++;
			$error("tx1 beat changed while stalled");
		end

endmodule

bind eth_loop_top eth_loop_props u_props (
	.clk156     (clk156),
	.eth_rst    (eth_rst),
	.tx_release (tx_release),
	.tx0_valid  (tx0_valid),
	.tx0_ready  (tx0_ready),
	.tx0_word   ({tx0_data, tx0_keep, tx0_last}),
	.tx1_valid  (tx1_valid),
	.tx1_ready  (tx1_ready),
	.tx1_word   ({tx1_data, tx1_keep, tx1_last}),
	.overflow0  (overflow0),
	.overflow1  (overflow1),
	.mem_flags  ({mem_a.wr_gnt, mem_a.rd_gnt, mem_a.rd_valid,
	              mem_b.wr_gnt, mem_b.rd_gnt, mem_b.rd_valid})
);

`default_nettype wire

//--- test/eth_loop_tb.sv
`timescale 1ns/1ps
`include "eth_loop_settings.svh"
`default_nettype none

module eth_loop_tb;
	import eth_loop_pkg::*;

	localparam int CLK_NS = 20;
	localparam int DRAIN_CYCLES = 400;
	localparam int TEST_CYCLES = (8 + `ETH_PREFILL + 40) + 160 + 120 + 400 + 160 + 5 * DRAIN_CYCLES;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;

	logic clk156, eth_rst;
	logic rx0_valid, rx0_last, rx1_valid, rx1_last;
	logic [`ETH_DATA_W-1:0] rx0_data, rx1_data, tx0_data, tx1_data;
	logic [`ETH_KEEP_W-1:0] rx0_keep, rx1_keep, tx0_keep, tx1_keep;
	logic tx0_valid, tx0_ready, tx0_last, tx1_valid, tx1_ready, tx1_last;
	logic overflow0, overflow1;

	eth_beat_t q_a [$]; // rx0 beats due on tx1
	eth_beat_t q_b [$]; // rx1 beats due on tx0
	int occ_a, occ_b, sent_tx1;
	int errors, checks, tests_run, tests_failed;
	logic [31:0] seed_rx0, seed_rx1, seed_rdy;
	logic [8:0] thr0, thr1; // ready odds out of 256

	eth_loop_top UUT (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// inline errors plus failed checker assertions
	function automatic int error_total();
		return errors + int'(UUT.u_props.fail_count);
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
		checks++;
		assert (exp == got) else begin
			errors++;
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic make_beat(input int port, output eth_beat_t b);
		logic [31:0] hi;
		logic [31:0] lo;
		if (port == 0) begin
			seed_rx0 = xorshift32(seed_rx0);
			hi = seed_rx0;
			seed_rx0 = xorshift32(seed_rx0);
			lo = seed_rx0;
		end else begin
			seed_rx1 = xorshift32(seed_rx1);
			hi = seed_rx1;
			seed_rx1 = xorshift32(seed_rx1);
			lo = seed_rx1;
		end
		b.data = {hi, lo};
		b.keep = hi[7:0] | 8'h01; // at least one byte
		b.last = lo[0];
	endtask

	// one beat every second cycle and queued only if the region has room
	task automatic send_burst(input int port, input int n);
		eth_beat_t b;
		for (int i = 0; i < n; i++) begin
			@(posedge clk156);
			#2;
			make_beat(port, b);
			if (port == 0) begin
				{rx0_valid, rx0_data, rx0_keep, rx0_last} = {1'b1, b};
				if (occ_a < `ETH_REGION_DEPTH) begin
					q_a.push_back(b);
					occ_a++;
				end
			end else begin
				{rx1_valid, rx1_data, rx1_keep, rx1_last} = {1'b1, b};
				if (occ_b < `ETH_REGION_DEPTH) begin
					q_b.push_back(b);
					occ_b++;
				end
			end
			@(posedge clk156);
			#2;
			if (port == 0)
				rx0_valid = 1'b0;
			else
				rx1_valid = 1'b0;
		end
	endtask

	task automatic check_tx(input int port, input eth_beat_t got);
		eth_beat_t exp;
		string pfx;
		pfx = (port == 1) ? "tx1" : "tx0";
		if ((port == 1 && q_a.size() == 0) || (port == 0 && q_b.size() == 0)) begin
			errors++;
			$display("%s sent a beat at %0t with nothing pending for it", pfx, $time);
			return;
		end
		if (port == 1) begin
			exp = q_a.pop_front();
			occ_a--;
			sent_tx1++;
		end else begin
			exp = q_b.pop_front();
			occ_b--;
		end
		compare({pfx, "_data"}, exp.data, got.data);
		compare({pfx, "_keep"}, 64'(exp.keep), 64'(got.keep));
		compare({pfx, "_last"}, 64'(exp.last), 64'(got.last));
	endtask

	task automatic set_ready(input logic [8:0] t0, input logic [8:0] t1);
		@(negedge clk156);
		thr0 = t0;
		thr1 = t1;
	endtask

	task automatic wait_drained(input string what);
		int n;
		n = 0;
		while ((q_a.size() != 0 || q_b.size() != 0) && n < DRAIN_CYCLES) begin
			@(posedge clk156);
			n++;
		end
		if (q_a.size() != 0 || q_b.size() != 0) begin
			errors++;
			$display("%s: %0d rx0 and %0d rx1 beats never came out", what, q_a.size(), q_b.size());
		end
		repeat (4) @(posedge clk156); // lets stray beats show
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (error_total() == err_before) begin
			$display("test %s ok", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, error_total() - err_before);
		end
	endtask

	initial begin
		clk156 = 1'b0;
		forever #(CLK_NS / 2) clk156 = ~clk156;
	end

	// transfer seen at negedge takes place at the next rising edge
	always @(negedge clk156) begin
		if (!eth_rst && tx1_valid && tx1_ready)
			check_tx(1, '{data: tx1_data, keep: tx1_keep, last: tx1_last});
		if (!eth_rst && tx0_valid && tx0_ready)
			check_tx(0, '{data: tx0_data, keep: tx0_keep, last: tx0_last});
	end

	always @(posedge clk156) begin
		#2;
		seed_rdy = xorshift32(seed_rdy);
		tx0_ready = ({1'b0, seed_rdy[7:0]} < thr0);
		tx1_ready = ({1'b0, seed_rdy[15:8]} < thr1);
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int e0;
		int n_tx1;
		{rx0_valid, rx0_data, rx0_keep, rx0_last} = '0;
		{rx1_valid, rx1_data, rx1_keep, rx1_last} = '0;
		{tx0_ready, tx1_ready} = 2'b00;
		occ_a = 0;
		occ_b = 0;
		sent_tx1 = 0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		thr0 = 9'd256;
		thr1 = 9'd256;
		seed_rx0 = 32'haa19;
		seed_rx1 = xorshift32(seed_rx0); // streams split from one seed
		seed_rdy = xorshift32(seed_rx1);
		eth_rst = 1'b1;
		repeat (8) @(posedge clk156);
		#2;
		eth_rst = 1'b0;

		e0 = error_total(); // beats arrive while transmit is still held
		fork
			send_burst(0, 20);
			send_burst(1, 20);
		join
		wait_drained("startup");
		end_test("startup", e0);

		e0 = error_total();
		send_burst(0, 40);
		send_burst(1, 40);
		wait_drained("cross_order");
		end_test("cross_order", e0);

		e0 = error_total();
		set_ready(9'd128, 9'd128);
		fork
			send_burst(0, 30);
			send_burst(1, 30);
		join
		wait_drained("backpressure");
		end_test("backpressure", e0);

		e0 = error_total();
		set_ready(9'd192, 9'd192);
		fork
			send_burst(0, 200);
			send_burst(1, 200);
		join
		wait_drained("concurrent");
		compare("overflow0", 64'd0, 64'(overflow0));
		compare("overflow1", 64'd0, 64'(overflow1));
		end_test("concurrent", e0);

		e0 = error_total(); // with tx1 stalled the region fills and drops the rest
		set_ready(9'd256, 9'd0);
		n_tx1 = sent_tx1;
		send_burst(0, 70);
		repeat (4) @(negedge clk156);
		compare("overflow0", 64'd1, 64'(overflow0));
		compare("overflow1", 64'd0, 64'(overflow1));
		set_ready(9'd256, 9'd256);
		wait_drained("overflow");
		compare("tx1 beat count", 64'(`ETH_REGION_DEPTH), 64'(sent_tx1 - n_tx1));
		end_test("overflow", e0);

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, error_total());
		if (error_total() == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
